// File: all.f
+incdir+rtl
+incdir+verif
rtl/raster_pkg.sv
rtl/skid_buffer.sv
rtl/sample_stepper.sv
rtl/test_iterator.sv
verif/test_iterator_tb.sv

// File: rtl/raster_config.svh
`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

// Fixed-point format for positions and colour
// Integer part sits in [SIGFIG-1:RADIX], fraction in [RADIX-1:0]
`define SIGFIG 24
`define RADIX 10

// Triangle geometry
// Up to three vertices, each with x, y and z
`define VERTS 3
`define AXIS 3

// Colour channels carried per triangle
`define COLORS 3

// Sub-sample step shift is RADIX minus this bias
// 1000 -> 1 pixel, 0100 -> half, 0010 -> quarter, 0001 -> eighth
`define SUB_SHIFT_BIAS 3

`endif

// File: rtl/raster_pkg.sv
`default_nettype none

`include "raster_config.svh"

package raster_pkg;

    // Signed fixed-point coordinate
    typedef logic signed [`SIGFIG-1:0] fixed_t;

    // Unsigned colour channel, same fixed-point layout
    typedef logic [`SIGFIG-1:0] color_t;

    // Screen position
    typedef struct packed {
        fixed_t x;
        fixed_t y;
    } point_t;

    // One vertex, index 0 is x, 1 is y, 2 is z
    typedef fixed_t [`AXIS-1:0] vertex_t;

    // Bounding box corners
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    // One-hot sub-sample code
    // 1000 for 1x, 0100 for 4x, 0010 for 16x, 0001 for 64x
    typedef logic [3:0] sub_sample_t;

    // Triangle as it enters the iterator
    typedef struct packed {
        vertex_t [`VERTS-1:0] verts;
        color_t [`COLORS-1:0] color;
        box_t box;
        sub_sample_t sub_sample;
    } tri_t;

    // Sample as it leaves, triangle data travels along
    typedef struct packed {
        vertex_t [`VERTS-1:0] verts;
        color_t [`COLORS-1:0] color;
        point_t pt;
    } sample_t;

endpackage

`default_nettype wire

// File: rtl/sample_stepper.sv
`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

module sample_stepper (
    input  logic               clk,
    input  logic               rst,
    input  raster_pkg::tri_t   tri_data,
    input  logic               tri_valid,
    output logic               tri_ready,
    output raster_pkg::sample_t samp_data,
    output logic               samp_valid,
    input  logic               samp_ready
);

    import raster_pkg::*;

    // Sub-sample code is shifted up to land on the right fraction bit
    localparam int STEP_SHIFT = `RADIX - `SUB_SHIFT_BIAS;

    // Waiting for a triangle, or walking its box
    typedef enum logic {
        WAIT_ST,
        TEST_ST
    } state_t;

    state_t state_q;
    state_t state_d;

    // Captured triangle, box and sub-sample code
    tri_t tri_q;

    // Current sample position
    point_t point_q;
    point_t next_point;

    // Candidates for the next sample
    point_t rt_point;
    point_t up_point;
    fixed_t step;

    // Edge flags, from current registers only
    logic at_right_edge;
    logic at_top_edge;
    logic at_end_box;

    logic tri_fire;
    logic samp_fire;

    // Handshakes follow the state directly
    assign tri_ready = (state_q == WAIT_ST);
    assign samp_valid = (state_q == TEST_ST);

    assign tri_fire = tri_valid & tri_ready;
    assign samp_fire = samp_valid & samp_ready;

    // Sample spacing in fixed point
    // Code is unsigned so it zero-extends before the shift
    assign step = fixed_t'(tri_q.sub_sample) << STEP_SHIFT;

    always_comb begin
        // Step right along the current row
        rt_point.x = point_q.x + step;
        rt_point.y = point_q.y;

        // Wrap back to the left edge one row up
        up_point.x = tri_q.box.ll.x;
        up_point.y = point_q.y + step;
    end

    // Signed compares against the upper-right corner
    assign at_right_edge = (point_q.x >= tri_q.box.ur.x);
    assign at_top_edge = (point_q.y >= tri_q.box.ur.y);
    assign at_end_box = at_right_edge & at_top_edge;

    // Scan order, left to right then bottom to top
    assign next_point = at_right_edge ? up_point : rt_point;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            WAIT_ST: begin
                if (tri_valid) begin
                    state_d = TEST_ST;
                end
            end
            TEST_ST: begin
                // Leave only once the top-right sample has gone out
                if (samp_ready && at_end_box) begin
                    state_d = WAIT_ST;
                end
            end
            default: begin
                state_d = WAIT_ST;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= WAIT_ST;
        end else begin
            state_q <= state_d;
        end
    end

    // Triangle capture, held for the whole box
    always_ff @(posedge clk) begin
        if (tri_fire) begin
            tri_q <= tri_data;
        end
    end

    // Sample position
    // First sample is the lower-left corner of the new box
    always_ff @(posedge clk) begin
        if (tri_fire) begin
            point_q <= tri_data.box.ll;
        end else if (samp_fire && !at_end_box) begin
            point_q <= next_point;
        end
    end

    // Sample carries the triangle it belongs to
    always_comb begin
        samp_data.verts = tri_q.verts;
        samp_data.color = tri_q.color;
        samp_data.pt = point_q;
    end

endmodule

`default_nettype wire

// File: rtl/skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // Main entry drives the output directly
    payload_t main_q;
    logic main_valid;

    // Spill entry catches the item accepted while main is stalled
    // Spill holds data exactly when in_ready is low
    payload_t spill_q;

    logic in_fire;
    logic main_free;

    assign in_fire = in_valid & in_ready;

    // Main can take new data when empty or being drained this cycle
    assign main_free = ~main_valid | out_ready;

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            main_valid <= 1'b0;
            in_ready <= 1'b1;
        end else if (main_free) begin
            if (!in_ready) begin
                // Spill moves into main, spill empties
                main_valid <= 1'b1;
                in_ready <= 1'b1;
            end else begin
                // Input passes straight into main
                main_valid <= in_valid;
            end
        end else if (in_fire) begin
            // Main stalled, park the new item and stop the source
            in_ready <= 1'b0;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (main_free) begin
            if (!in_ready) begin
                main_q <= spill_q;
            end else if (in_valid) begin
                main_q <= in_data;
            end
        end
        // Spill only written when main is stalled
        if (!main_free && in_fire) begin
            spill_q <= in_data;
        end
    end

    // Output held steady while stalled
    assign out_data = main_q;
    assign out_valid = main_valid;

endmodule

`default_nettype wire

// File: rtl/test_iterator.sv
`timescale 1ns/1ps
`default_nettype none

module test_iterator (
    input  logic                clk,
    input  logic                rst,
    input  raster_pkg::tri_t    in_data,
    input  logic                in_valid,
    output logic                in_ready,
    output raster_pkg::sample_t out_data,
    output logic                out_valid,
    input  logic                out_ready
);

    import raster_pkg::*;

    // Triangle path from input buffer to stepper
    tri_t tri_data;
    logic tri_valid;
    logic tri_ready;

    // Sample path from stepper to output buffer
    sample_t samp_data;
    logic samp_valid;
    logic samp_ready;

    // Input side
    // Up to two triangles queue here while the stepper is busy
    skid_buffer #(
        .payload_t(tri_t)
    ) tri_buf_i (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (tri_data),
        .out_valid(tri_valid),
        .out_ready(tri_ready)
    );

    // Box walk, one triangle in flight
    sample_stepper stepper_i (
        .clk       (clk),
        .rst       (rst),
        .tri_data  (tri_data),
        .tri_valid (tri_valid),
        .tri_ready (tri_ready),
        .samp_data (samp_data),
        .samp_valid(samp_valid),
        .samp_ready(samp_ready)
    );

    // Output side
    // Registers the sample stream and absorbs back-pressure
    skid_buffer #(
        .payload_t(sample_t)
    ) samp_buf_i (
        .clk      (clk),
        .rst      (rst),
        .in_data  (samp_data),
        .in_valid (samp_valid),
        .in_ready (samp_ready),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the sample iterator testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    -f all.f \
    --top-module test_iterator_tb \
    -o test_iterator_sim

./obj_dir/test_iterator_sim | tee sim.log

# The log decides the result
if grep -q "^Everything OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

// File: verif/tri_table.svh
`ifndef TRI_TABLE_SVH
`define TRI_TABLE_SVH

// Stimulus table for the sample iterator
// Columns are ll_x, ll_y, ur_x, ur_y in eighths of a pixel, sub-sample code and sample count
// Counts are columns times rows of the box at the code's step

localparam int NUM_ROWS = 12;

row_t tri_table [NUM_ROWS];

task automatic fill_table();
    // 1x, pixels 2..5 by 3..4, four columns and two rows
    tri_table[0] = '{16, 24, 40, 32, 4'b1000, 8};

    // 4x over one pixel square, half-pixel step gives 3 by 3
    tri_table[1] = '{0, 0, 8, 8, 4'b0100, 9};

    // 16x, quarter step, 5 columns by 3 rows
    tri_table[2] = '{8, 8, 16, 12, 4'b0010, 15};

    // 64x, eighth step, 5 columns by 3 rows
    tri_table[3] = '{0, 0, 4, 2, 4'b0001, 15};

    // Degenerate box at (7, 9)
    tri_table[4] = '{56, 72, 56, 72, 4'b1000, 1};

    // Negative coordinates, 1x, 3 by 2
    tri_table[5] = '{-16, -8, 0, 0, 4'b1000, 6};

    // Degenerate box at (-3.5, 2) with the finest step
    tri_table[6] = '{-28, 16, -28, 16, 4'b0001, 1};

    // Right edge not on the step grid
    // x runs 0, 0.5, 1.0, 1.5 and stops past 1.25
    tri_table[7] = '{0, 0, 10, 4, 4'b0100, 8};

    // Single row, 1x
    tri_table[8] = '{80, 160, 96, 160, 4'b1000, 3};

    // 16x box across the origin, 4 by 3
    tri_table[9] = '{-4, -2, 2, 2, 4'b0010, 12};

    // 64x, small box away from the origin, 3 by 2
    tri_table[10] = '{24, 24, 26, 25, 4'b0001, 6};

    // Single column, every step wraps up a row
    tri_table[11] = '{32, 0, 32, 16, 4'b0100, 5};
endtask

`endif

// File: verif/test_iterator_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

module test_iterator_tb;

    import raster_pkg::*;

    localparam int SEND_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int STALL_CYCLES = 30;
    localparam int MAX_TRIS = 32;
    localparam int RDY_RANDOM = 0;
    localparam int RDY_LOW = 1;

    // Rows sent while the output is blocked
    localparam int STALL_ROWS [4] = '{0, 4, 8, 2};

    typedef vertex_t [`VERTS-1:0] verts_t;
    typedef color_t [`COLORS-1:0] colors_t;

    typedef struct {
        int llx8;
        int lly8;
        int urx8;
        int ury8;
        logic [3:0] sub;
        int count;
    } row_t;

    `include "tri_table.svh"

    logic clk;
    logic rst;
    tri_t in_data;
    logic in_valid;
    logic in_ready;
    sample_t out_data;
    logic out_valid;
    logic out_ready;

    // Expected sample stream and the triangle each one belongs to
    sample_t exp_q [$];
    int tag_q [$];
    int exp_count [MAX_TRIS];
    int got_count [MAX_TRIS];
    int tri_num;

    int val_errs;
    int proto_errs;
    int timeout_errs;

    // Written only at the falling edge, read by the sink after the rising edge
    int ready_mode = RDY_RANDOM;
    integer seed = 32'h443a_abe1;
    logic stall_seen;

    test_iterator dut_i (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    always #20 clk = ~clk;

    // Attributes unique per triangle, so mixing shows up
    function automatic verts_t tri_verts(input int k);
        verts_t v;
        for (int i = 0; i < `VERTS; i++) begin
            for (int a = 0; a < `AXIS; a++) begin
                v[i][a] = fixed_t'(k * 4096 + i * 64 + a * 8 + 1);
            end
        end
        return v;
    endfunction

    function automatic colors_t tri_colors(input int k);
        colors_t c;
        for (int i = 0; i < `COLORS; i++) begin
            c[i] = color_t'(((i + 1) << 20) + k * 16 + 5);
        end
        return c;
    endfunction

    // Triangle number recovered from the first vertex of a sample
    // Same encoding as tri_verts, -1 when it does not fit
    function automatic int tri_of_sample(input sample_t s);
        int v;
        v = int'(s.verts[0][0]) - 1;
        if (v < 0 || v % 4096 != 0) begin
            return -1;
        end
        return v / 4096;
    endfunction

    // 1x one pixel, 4x half, 16x quarter, 64x eighth (RADIX 10)
    function automatic int step_of(input logic [3:0] sub);
        case (sub)
            4'b1000: return 1024;
            4'b0100: return 512;
            4'b0010: return 256;
            4'b0001: return 128;
            default: return 1024;
        endcase
    endfunction

    function automatic tri_t make_tri(input int k, input row_t r);
        tri_t t;
        t.verts = tri_verts(k);
        t.color = tri_colors(k);
        t.box.ll.x = fixed_t'(r.llx8 * 128);
        t.box.ll.y = fixed_t'(r.lly8 * 128);
        t.box.ur.x = fixed_t'(r.urx8 * 128);
        t.box.ur.y = fixed_t'(r.ury8 * 128);
        t.sub_sample = r.sub;
        return t;
    endfunction

    // Reference scan goes left to right, then up one row, and ends at the top-right corner
    task automatic push_expected(input int k, input row_t r);
        sample_t s;
        int x;
        int y;
        int step;
        int n;
        step = step_of(r.sub);
        x = r.llx8 * 128;
        y = r.lly8 * 128;
        n = 0;
        s.verts = tri_verts(k);
        s.color = tri_colors(k);
        while (n < 4096) begin
            s.pt.x = fixed_t'(x);
            s.pt.y = fixed_t'(y);
            exp_q.push_back(s);
            tag_q.push_back(k);
            n++;
            if (x >= r.urx8 * 128 && y >= r.ury8 * 128) begin
                break;
            end
            if (x >= r.urx8 * 128) begin
                x = r.llx8 * 128;
                y = y + step;
            end else begin
                x = x + step;
            end
        end
        exp_count[k] = r.count;
    endtask

    // Called just after a rising edge; returns just after the edge of the transfer
    task automatic send_tri(input int row, input logic release_on_stall);
        int cycles;
        logic done;
        in_data = make_tri(tri_num, tri_table[row]);
        in_valid = 1'b1;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < SEND_TIMEOUT) begin
            @(negedge clk);
            if (in_ready) begin
                done = 1'b1;
            end else begin
                cycles++;
                // Input side is full, let the output drain again
                if (release_on_stall && cycles == STALL_CYCLES) begin
                    stall_seen = 1'b1;
                    ready_mode = RDY_RANDOM;
                end
            end
        end
        if (done) begin
            push_expected(tri_num, tri_table[row]);
        end else begin
            timeout_errs++;
            $display("Timeout: triangle %0d was never accepted", tri_num);
        end
        tri_num++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Returns at a rising edge
    task automatic drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            timeout_errs++;
            $display("Timeout: %0d samples never came out", exp_q.size());
        end
    endtask

    // Sink, random back-pressure and per-sample checks
    initial begin : sink_proc
        sample_t held;
        sample_t exp;
        int tag;
        int src;
        int rnd;
        logic prev_stall;
        out_ready = 1'b0;
        prev_stall = 1'b0;
        held = '0;
        forever begin
            @(posedge clk);
            #1;
            if (ready_mode == RDY_LOW) begin
                out_ready = 1'b0;
            end else begin
                rnd = $random(seed);
                out_ready = (rnd[1:0] != 2'b00);
            end
            @(negedge clk);
            if (prev_stall) begin
                assert (out_valid && out_data == held) else begin
                    val_errs++;
                    $display("Fail %0t: output changed while stalled", $time);
                end
            end
            if (out_valid && out_ready) begin
                // Per-triangle count taken from what the DUT actually sent
                src = tri_of_sample(out_data);
                if (src >= 0 && src < MAX_TRIS) begin
                    got_count[src]++;
                end
                assert (exp_q.size() > 0) else begin
                    proto_errs++;
                    $display("Extra sample at (%0d,%0d) with none outstanding",
                             out_data.pt.x, out_data.pt.y);
                end
                if (exp_q.size() > 0) begin
                    exp = exp_q.pop_front();
                    tag = tag_q.pop_front();
                    assert (out_data.pt == exp.pt) else begin
                        val_errs++;
                        $display("Fail %0t: triangle %0d got (%0d,%0d) expected (%0d,%0d)",
                                 $time, tag, out_data.pt.x, out_data.pt.y,
                                 exp.pt.x, exp.pt.y);
                    end
                    assert (out_data.verts == exp.verts && out_data.color == exp.color)
                    else begin
                        val_errs++;
                        $display("Fail %0t: triangle %0d sample carries wrong vertices or colour",
                                 $time, tag);
                    end
                end
            end
            prev_stall = out_valid && !out_ready;
            held = out_data;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        val_errs = 0;
        proto_errs = 0;
        timeout_errs = 0;
        tri_num = 0;
        stall_seen = 1'b0;
        for (int i = 0; i < MAX_TRIS; i++) begin
            exp_count[i] = 0;
            got_count[i] = 0;
        end
        fill_table();

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        assert (!out_valid && in_ready) else begin
            val_errs++;
            $display("Fail %0t: after reset out_valid=%0b in_ready=%0b",
                     $time, out_valid, in_ready);
        end

        // Whole table back to back under random back-pressure
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_tri(i, 1'b0);
        end
        drain();

        // Output blocked until the input side fills up
        @(negedge clk);
        ready_mode = RDY_LOW;
        @(posedge clk);
        #1;
        for (int i = 0; i < 4; i++) begin
            send_tri(STALL_ROWS[i], 1'b1);
        end
        @(negedge clk);
        ready_mode = RDY_RANDOM;
        drain();
        assert (stall_seen) else begin
            proto_errs++;
            $display("in_ready never fell while out_ready was held low");
        end

        // Idle stretch catches late or duplicated samples
        repeat (20) @(negedge clk);

        for (int k = 0; k < tri_num; k++) begin
            assert (got_count[k] == exp_count[k]) else begin
                val_errs++;
                $display("Fail %0t: triangle %0d gave %0d samples, expected %0d",
                         $time, k, got_count[k], exp_count[k]);
            end
        end

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 val_errs, proto_errs, timeout_errs);
        if (val_errs + proto_errs + timeout_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
